/* sim.f */
common/mult_pkg.sv
mult_fu/mult_decode.sv
mult_fu/mult_execute.sv
mult_fu/mult_result.sv
rtl/mult_unit.sv
sim/tb_mult_unit.sv

/* Bender.yml */
package:
  name: mult_unit

sources:
  - files:
      - common/mult_pkg.sv
      - mult_fu/mult_decode.sv
      - mult_fu/mult_execute.sv
      - mult_fu/mult_result.sv
      - rtl/mult_unit.sv
  - target: simulation
    files:
      - sim/tb_mult_unit.sv

/* sim/tb_mult_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_mult_unit import mult_pkg::*; ();

	localparam int BPC      = 2;
	localparam int N        = XLEN / BPC;  // multiplier cycles
	localparam int N_RANDOM = 200;
	localparam int N_CORNER = 4 * 5 * 5;
	localparam int N_LATE   = 20;
	localparam int N_BUSY   = 10;
	localparam int N_SQUASH = 10;
	localparam int NUM_OPS  = N_RANDOM + N_CORNER + N_LATE + 2 * N_BUSY + 2 * N_SQUASH;
	localparam int TIMEOUT  = NUM_OPS * (N + 8) + 200;  // in clock periods

	logic    clock;
	logic    arst_n;
	logic    issue_valid;
	funct3_t funct3;
	word_t   opa;
	word_t   opb;
	logic    operand_ready;
	logic    operand_update;
	tag_t    dest_tag;
	logic    squash;
	logic    busy;
	logic    result_valid;
	word_t   result;
	tag_t    result_tag;

	// expected results, in issue order
	word_t exp_res_q[$];
	tag_t  exp_tag_q[$];
	int    exp_edge_q[$];  // edge at which operands became ready

	string test_name = "reset";
	int    cycle     = 0;
	int    errors    = 0;
	int    checked   = 0;
	int    test_ops  = 0;
	int    test_err0 = 0;

	mult_unit #(
		.BITS_PER_CYCLE (BPC)
	) mult_unit_i (
		.clock          (clock),
		.arst_n         (arst_n),
		.issue_valid    (issue_valid),
		.funct3         (funct3),
		.opa            (opa),
		.opb            (opb),
		.operand_ready  (operand_ready),
		.operand_update (operand_update),
		.dest_tag       (dest_tag),
		.squash         (squash),
		.busy           (busy),
		.result_valid   (result_valid),
		.result         (result),
		.result_tag     (result_tag)
	);

	initial begin
		clock = 1'b0;
		forever #20 clock = ~clock;
	end

	always @(posedge clock)
		cycle <= cycle + 1;

	// RV32M: rs1 signed unless MULHU, rs2 signed only for MUL and MULH
	function automatic word_t ref_mult(input funct3_t f3, input word_t a, input word_t b);
		dword_t ax;
		dword_t bx;
		dword_t p;
		ax = (f3 == 3'd3) ? {{XLEN{1'b0}}, a} : {{XLEN{a[XLEN-1]}}, a};
		bx = (f3 <= 3'd1) ? {{XLEN{b[XLEN-1]}}, b} : {{XLEN{1'b0}}, b};
		p  = ax * bx;  // modulo 2^64 is enough for both halves
		return (f3 == 3'd0) ? p[XLEN-1:0] : p[2*XLEN-1:XLEN];
	endfunction

	function automatic word_t corner(input int i);
		case (i)
			0:       return '0;
			1:       return word_t'(1);
			2:       return '1;
			3:       return {1'b1, {(XLEN-1){1'b0}}};  // most negative
			default: return {1'b0, {(XLEN-1){1'b1}}};  // most positive
		endcase
	endfunction

	// compares every result pulse against the queue
	always @(negedge clock) begin
		word_t exp_res;
		tag_t  exp_tag;
		int    exp_edge;
		if (arst_n && result_valid) begin
			assert (exp_res_q.size() != 0) else begin
				$display("%s: result_valid seen with no operation outstanding", test_name);
				errors++;
			end
			if (exp_res_q.size() != 0) begin
				exp_res  = exp_res_q.pop_front();
				exp_tag  = exp_tag_q.pop_front();
				exp_edge = exp_edge_q.pop_front();
				checked++;
				assert (result === exp_res) else begin
					$display("ERR %s result expected %h actual %h", test_name, exp_res, result);
					errors++;
				end
				assert (result_tag === exp_tag) else begin
					$display("ERR %s tag expected %h actual %h", test_name, exp_tag, result_tag);
					errors++;
				end
				assert (cycle + 1 - exp_edge == N + 2) else begin
					$display("ERR %s latency expected %0d actual %0d", test_name, N + 2,
						cycle + 1 - exp_edge);
					errors++;
				end
			end
		end
	end

	task automatic wait_idle();
		while (busy)
			@(negedge clock);
	endtask

	// drives one issue strobe, queues the expected result when asked
	task automatic issue_op(input funct3_t f3, input word_t a, input word_t b, input tag_t tg,
			input logic rdy, input bit expect_it);
		issue_valid   = 1'b1;
		funct3        = f3;
		opa           = a;
		opb           = b;
		dest_tag      = tg;
		operand_ready = rdy;
		if (rdy && expect_it) begin
			exp_res_q.push_back(ref_mult(f3, a, b));
			exp_tag_q.push_back(tg);
			exp_edge_q.push_back(cycle + 1);
		end
		@(negedge clock);
		issue_valid   = 1'b0;
		operand_ready = 1'b0;
		opa           = $urandom;  // garbage, must not be used
		opb           = $urandom;
	endtask

	task automatic update_operands(input funct3_t f3, input word_t a, input word_t b,
			input tag_t tg);
		operand_update = 1'b1;
		opa            = a;
		opb            = b;
		exp_res_q.push_back(ref_mult(f3, a, b));
		exp_tag_q.push_back(tg);
		exp_edge_q.push_back(cycle + 1);
		@(negedge clock);
		operand_update = 1'b0;
	endtask

	task automatic begin_test(input string name);
		test_name = name;
		test_ops  = 0;
		test_err0 = errors;
	endtask

	task automatic end_test();
		while (exp_res_q.size() != 0)
			@(negedge clock);
		$display("test %s finished: %0d operations, %0d errors", test_name, test_ops,
			errors - test_err0);
	endtask

	initial begin
		funct3_t f3;
		word_t   a;
		word_t   b;
		tag_t    tg;
		int      d;
		void'($urandom(32'h1c280dbe));
		arst_n         = 1'b0;
		issue_valid    = 1'b0;
		funct3         = '0;
		opa            = '0;
		opb            = '0;
		operand_ready  = 1'b0;
		operand_update = 1'b0;
		dest_tag       = '0;
		squash         = 1'b0;
		repeat (10) @(negedge clock);
		arst_n = 1'b1;
		@(negedge clock);

		begin_test("random");
		repeat (N_RANDOM) begin
			f3 = funct3_t'($urandom_range(3, 0));
			a  = $urandom;
			b  = $urandom;
			tg = tag_t'($urandom);
			wait_idle();
			issue_op(f3, a, b, tg, 1'b1, 1'b1);
			test_ops++;
		end
		end_test();

		begin_test("corner");
		for (int f = 0; f < 4; f++)
			for (int i = 0; i < 5; i++)
				for (int j = 0; j < 5; j++) begin
					wait_idle();
					issue_op(funct3_t'(f), corner(i), corner(j), tag_t'(i * 5 + j), 1'b1, 1'b1);
					test_ops++;
				end
		end_test();

		begin_test("late_operands");
		repeat (N_LATE) begin
			f3 = funct3_t'($urandom_range(3, 0));
			a  = $urandom;
			b  = $urandom;
			tg = tag_t'($urandom);
			wait_idle();
			issue_op(f3, $urandom, $urandom, tg, 1'b0, 1'b0);
			d = $urandom_range(10, 0);
			repeat (d) @(negedge clock);
			update_operands(f3, a, b, tg);
			test_ops++;
		end
		end_test();

		begin_test("issue_while_busy");
		repeat (N_BUSY) begin
			wait_idle();
			issue_op(funct3_t'($urandom_range(3, 0)), $urandom, $urandom, tag_t'($urandom),
				1'b1, 1'b1);
			d = $urandom_range(N - 1, 0);
			repeat (d) @(negedge clock);
			assert (busy) else begin
				$display("%s: busy was low where the unit should still be working", test_name);
				errors++;
			end
			issue_op(funct3_t'($urandom_range(3, 0)), $urandom, $urandom, tag_t'($urandom),
				1'b1, 1'b0);  // must be dropped
			repeat (N + 4) @(negedge clock);
			test_ops += 2;
		end
		end_test();

		begin_test("squash");
		repeat (N_SQUASH) begin
			wait_idle();
			issue_op(funct3_t'($urandom_range(3, 0)), $urandom, $urandom, tag_t'($urandom),
				1'b1, 1'b0);
			d = $urandom_range(N - 1, 0);
			repeat (d) @(negedge clock);
			squash = 1'b1;
			@(negedge clock);
			squash = 1'b0;
			assert (!busy) else begin
				$display("%s: busy still high in the cycle after the squash", test_name);
				errors++;
			end
			repeat (N + 4) @(negedge clock);  // any result here is flagged by the checker
			f3 = funct3_t'($urandom_range(3, 0));
			wait_idle();
			issue_op(f3, $urandom, $urandom, tag_t'($urandom), 1'b1, 1'b1);
			test_ops += 2;
		end
		end_test();

		@(negedge clock);
		$display("checked %0d results, %0d errors", checked, errors);
		if (errors == 0)
			$display("Done: no errors");
		else
			$display("Done: errors found");
		$finish;
	end

	// watchdog
	initial begin
		repeat (TIMEOUT + 10) @(posedge clock);
		$display("timeout: the run did not finish within %0d clock periods", TIMEOUT);
		$display("Done: errors found");
		$finish;
	end

endmodule

`default_nettype wire

/* rtl/mult_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module mult_unit import mult_pkg::*; #(
	parameter int BITS_PER_CYCLE = 2  // multiplier digits per cycle
) (
	input  logic    clock,
	input  logic    arst_n,
	input  logic    issue_valid,
	input  funct3_t funct3,
	input  word_t   opa,
	input  word_t   opb,
	input  logic    operand_ready,
	input  logic    operand_update,
	input  tag_t    dest_tag,
	input  logic    squash,
	output logic    busy,
	output logic    result_valid,
	output word_t   result,
	output tag_t    result_tag
);
	logic     start;
	word_t    mag_a;
	word_t    mag_b;
	mult_op_e op;
	logic     negate;
	tag_t     tag;
	logic     done;
	dword_t   product;

	mult_decode decode_i (
		.clock          (clock),
		.arst_n         (arst_n),
		.issue_valid    (issue_valid),
		.funct3         (funct3),
		.opa            (opa),
		.opb            (opb),
		.operand_ready  (operand_ready),
		.operand_update (operand_update),
		.dest_tag       (dest_tag),
		.squash         (squash),
		.result_valid   (result_valid),  // frees the held op
		.busy           (busy),
		.start          (start),
		.mag_a          (mag_a),
		.mag_b          (mag_b),
		.op             (op),
		.negate         (negate),
		.tag            (tag)
	);

	mult_execute #(
		.BITS_PER_CYCLE (BITS_PER_CYCLE)
	) execute_i (
		.clock   (clock),
		.arst_n  (arst_n),
		.start   (start),
		.mag_a   (mag_a),
		.mag_b   (mag_b),
		.squash  (squash),
		.done    (done),
		.product (product)
	);

	mult_result result_i (
		.clock        (clock),
		.arst_n       (arst_n),
		.done         (done),
		.product      (product),
		.op           (op),
		.negate       (negate),
		.tag          (tag),
		.squash       (squash),
		.result_valid (result_valid),
		.result       (result),
		.result_tag   (result_tag)
	);

endmodule

`default_nettype wire

/* mult_fu/mult_result.sv */
`timescale 1ns/1ps
`default_nettype none

module mult_result import mult_pkg::*; (
	input  logic     clock,
	input  logic     arst_n,
	input  logic     done,
	input  dword_t   product,
	input  mult_op_e op,
	input  logic     negate,
	input  tag_t     tag,
	input  logic     squash,
	output logic     result_valid,
	output word_t    result,
	output tag_t     result_tag
);
	dword_t signed_prod;

	// magnitudes were multiplied, put the sign back on the full product
	assign signed_prod = negate ? -product : product;

	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n)
			result_valid <= 1'b0;
		else
			result_valid <= done && !squash;  // squashed op never reports
	end

	always_ff @(posedge clock) begin
		if (done) begin
			if (op == MUL_LO)
				result <= signed_prod[XLEN-1:0];
			else
				result <= signed_prod[2*XLEN-1:XLEN];
			result_tag <= tag;
		end
	end

	a_result_pulse: assert property (@(posedge clock) disable iff (!arst_n)
		result_valid |=> !result_valid);

endmodule

`default_nettype wire

/* mult_fu/mult_execute.sv */
`timescale 1ns/1ps
`default_nettype none

module mult_execute import mult_pkg::*; #(
	parameter int BITS_PER_CYCLE = 2
) (
	input  logic   clock,
	input  logic   arst_n,
	input  logic   start,
	input  word_t  mag_a,
	input  word_t  mag_b,
	input  logic   squash,
	output logic   done,
	output dword_t product
);
	localparam int N  = XLEN / BITS_PER_CYCLE;  // digits per operand
	localparam int CW = $clog2(N);

	typedef logic [XLEN+BITS_PER_CYCLE-1:0] wide_t;

	if (BITS_PER_CYCLE < 1 || XLEN % BITS_PER_CYCLE != 0 || N < 2) begin : g_bad_digit
		$error("BITS_PER_CYCLE must divide XLEN and leave at least two digits");
	end

	exec_state_e      state_q;
	logic [CW-1:0]    count_q;
	dword_t           prod_q;  // {partial sum, remaining multiplier digits}

	// one radix-2^B digit of the multiplier, consumed from the low end
	function automatic dword_t shift_add(input dword_t acc, input word_t mcand);
		wide_t sum;
		sum = wide_t'(acc[2*XLEN-1:XLEN]);
		for (int i = 0; i < BITS_PER_CYCLE; i++) begin
			if (acc[i])
				sum = sum + (wide_t'(mcand) << i);
		end
		return {sum, acc[XLEN-1:BITS_PER_CYCLE]};
	endfunction

	assign done    = (state_q == DONE);
	assign product = prod_q;

	// first digit is taken at the start edge, N-1 more in RUN
	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			state_q <= IDLE;
			count_q <= '0;
		end else if (squash) begin
			state_q <= IDLE;
			count_q <= '0;
		end else begin
			case (state_q)
				IDLE: begin
					if (start) begin
						state_q <= RUN;
						count_q <= '0;
					end
				end
				RUN: begin
					if (count_q == CW'(N - 2))
						state_q <= DONE;  // last digit lands this edge
					else
						count_q <= count_q + 1'b1;
				end
				default: state_q <= IDLE;  // DONE lasts one cycle
			endcase
		end
	end

	// mag_a and mag_b stay stable until done
	always_ff @(posedge clock) begin
		if (state_q == IDLE && start)
			prod_q <= shift_add(dword_t'(mag_b), mag_a);
		else if (state_q == RUN)
			prod_q <= shift_add(prod_q, mag_a);
	end

	// done follows start by N cycles and lasts one
	a_done_pulse: assert property (@(posedge clock) disable iff (!arst_n || squash)
		state_q == IDLE && start |=> !done [*N-1] ##1 done ##1 !done);

endmodule

`default_nettype wire

/* mult_fu/mult_decode.sv */
`timescale 1ns/1ps
`default_nettype none

module mult_decode import mult_pkg::*; (
	input  logic     clock,
	input  logic     arst_n,
	input  logic     issue_valid,
	input  funct3_t  funct3,
	input  word_t    opa,
	input  word_t    opb,
	input  logic     operand_ready,
	input  logic     operand_update,
	input  tag_t     dest_tag,
	input  logic     squash,
	input  logic     result_valid,
	output logic     busy,
	output logic     start,
	output word_t    mag_a,
	output word_t    mag_b,
	output mult_op_e op,
	output logic     negate,
	output tag_t     tag
);
	logic     pending_q;  // an operation is held
	logic     waiting_q;  // held, operands still missing
	logic     accept;
	logic     ready_edge;
	mult_op_e op_next;
	mult_op_e sel_op;
	logic     a_neg;
	logic     b_neg;

	// slot frees in the result cycle itself
	assign busy       = pending_q && !result_valid;
	assign accept     = issue_valid && !busy;
	assign ready_edge = (accept && operand_ready) || (waiting_q && operand_update);

	always_comb begin
		case (funct3)
			F3_MULH:   op_next = MUL_HI_SS;
			F3_MULHSU: op_next = MUL_HI_SU;
			F3_MULHU:  op_next = MUL_HI_UU;
			default:   op_next = MUL_LO;  // F3_MUL
		endcase
	end

	// late operands use the op latched at issue
	always_comb begin
		sel_op = waiting_q ? op : op_next;
		a_neg  = (sel_op != MUL_HI_UU) && opa[XLEN-1];
		b_neg  = (sel_op == MUL_LO || sel_op == MUL_HI_SS) && opb[XLEN-1];
	end

	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			pending_q <= 1'b0;
			waiting_q <= 1'b0;
			start     <= 1'b0;
		end else if (squash) begin
			pending_q <= 1'b0;
			waiting_q <= 1'b0;
			start     <= 1'b0;
		end else begin
			start <= ready_edge;  // one pulse per operation
			if (accept) begin
				pending_q <= 1'b1;
				waiting_q <= !operand_ready;
			end else begin
				if (result_valid)
					pending_q <= 1'b0;
				if (waiting_q && operand_update)
					waiting_q <= 1'b0;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (accept) begin
			op  <= op_next;
			tag <= dest_tag;
		end
		if (ready_edge) begin
			mag_a  <= a_neg ? -opa : opa;
			mag_b  <= b_neg ? -opb : opb;
			negate <= a_neg ^ b_neg;
		end
	end

	// no second start until the running operation returns or is squashed
	a_single_start: assert property (@(posedge clock) disable iff (!arst_n)
		start && !squash |=> !start until (result_valid || squash));

	// update and issue together while idle
	a_update_on_issue: assert property (@(posedge clock) disable iff (!arst_n)
		!(issue_valid && !busy && operand_update));

endmodule

`default_nettype wire

/* common/mult_pkg.sv */
`default_nettype none

package mult_pkg;

	// datapath width, one RV32 word
	localparam int XLEN = 32;

	typedef logic [XLEN-1:0]   word_t;   // operands and result
	typedef logic [2*XLEN-1:0] dword_t;  // full product
	typedef logic [5:0]        tag_t;    // physical destination register
	typedef logic [2:0]        funct3_t;

	// RV32M funct3 encodings handled by this unit
	localparam funct3_t F3_MUL    = 3'd0;
	localparam funct3_t F3_MULH   = 3'd1;
	localparam funct3_t F3_MULHSU = 3'd2;
	localparam funct3_t F3_MULHU  = 3'd3;

	// decoded operation
	// selects signedness of each operand and which product half comes back
	typedef enum logic [1:0] {
		MUL_LO,     // low word, signedness irrelevant
		MUL_HI_SS,  // signed x signed
		MUL_HI_SU,  // signed x unsigned
		MUL_HI_UU   // unsigned x unsigned
	} mult_op_e;

	// iterative multiplier FSM
	typedef enum logic [1:0] {
		IDLE,
		RUN,
		DONE
	} exec_state_e;

endpackage

`default_nettype wire
